// ==== hdl/cpu900_defs.svh ====
/* cpu900 front end build constants
   queue size, current register bank and program memory width */

`ifndef CPU900_DEFS_SVH
`define CPU900_DEFS_SVH

// operand queue size in bytes as a power of two
`define CPU900_OPQ_DEPTH 8

// first byte address of the current register bank
`define CPU900_BANK_BASE 8'hE0

// word address width of the program memory
`define CPU900_MEM_AW 12

`endif

// ==== hdl/cpu900_data_pkg.sv ====
/* cpu900 data types
   byte, data, register address and size vectors plus the writeback record */

`default_nettype none

`include "cpu900_defs.svh"

package cpu900_data_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] data_t;      // register and immediate data
    typedef logic [7:0]  reg_addr_t;  // register byte address
    typedef logic [1:0]  op_size_t;   // zz field of the prefix

    typedef logic [`CPU900_MEM_AW-1:0] mem_addr_t;

    localparam op_size_t SZ_BYTE = 2'd0;
    localparam op_size_t SZ_WORD = 2'd1;
    localparam op_size_t SZ_LONG = 2'd2;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;   // first byte written
        data_t     data;   // already masked to size
        op_size_t  size;
    } wb_t;

endpackage

`default_nettype wire

// ==== hdl/cpu900_ctrl_pkg.sv ====
/* cpu900 decoder types
   decode phases, ALU operations and the decoder to register unit command */

`default_nettype none

package cpu900_ctrl_pkg;

    import cpu900_data_pkg::*;

    typedef enum logic [1:0] {
        FETCH,     // first opcode byte
        EXEC,      // second opcode byte
        FILL_IMM   // rest of a word or long immediate
    } phase_t;

    typedef enum logic [5:0] {
        ALU_NOP  = 6'd0,
        ALU_MOVE = 6'd1
    } alu_op_t;

    typedef struct packed {
        alu_op_t   op;
        reg_addr_t src;
        reg_addr_t dst;
        data_t     imm;
        logic      smux;   // 1 selects imm over src
        op_size_t  size;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/cpu900_opq.sv ====
/* cpu900 operand queue
   prefetches program words into a byte ring and shows a four byte opcode window */

`default_nettype none

`include "cpu900_defs.svh"

module cpu900_opq (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    output logic                       mem_req,
    output cpu900_data_pkg::mem_addr_t mem_addr,
    input  logic                       mem_ack,
    input  cpu900_data_pkg::data_t     mem_data,
    input  logic [1:0]                 fetched,
    output cpu900_data_pkg::data_t     op_win,
    output logic                       op_ok
);
    import cpu900_data_pkg::*;

    localparam int DEPTH = `CPU900_OPQ_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    typedef logic [PW-1:0] ptr_t;
    typedef logic [PW:0]   cnt_t;

    byte_t qbuf [DEPTH];
    ptr_t  rd_ptr;
    ptr_t  wr_ptr;
    cnt_t  count;     // valid bytes
    logic  pending;   // request waiting for its ack
    logic  push;

    // oldest byte sits in the low bits
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op_win[8*i +: 8] = qbuf[rd_ptr + ptr_t'(i)];
        end
    end

    assign op_ok   = count >= cnt_t'(4);
    assign mem_req = cen && !pending && (count <= cnt_t'(DEPTH - 4)); // room for a full word
    assign push    = cen && mem_ack && pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            pending  <= 1'b0;
            mem_addr <= '0;
        end else if (cen) begin
            if (mem_req) begin
                pending  <= 1'b1;
                mem_addr <= mem_addr + 1'b1;  // next word
            end else if (push) begin
                pending <= 1'b0;
            end
            if (push) begin
                wr_ptr <= wr_ptr + ptr_t'(4);
            end
            rd_ptr <= rd_ptr + ptr_t'(fetched);
            count  <= count + (push ? cnt_t'(4) : cnt_t'(0)) - cnt_t'(fetched);
        end
    end

    // byte ring storage
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < 4; i++) begin
                qbuf[wr_ptr + ptr_t'(i)] <= mem_data[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu900_ctrl.sv ====
/* cpu900 opcode decoder
   phase FSM for register and immediate loads, issues one move per instruction */

`default_nettype none

module cpu900_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  cpu900_data_pkg::data_t op_win,
    input  logic                   op_ok,
    output logic [1:0]             fetched,
    output cpu900_ctrl_pkg::ctrl_t ctrl,
    output logic                   alu_wait
);
    import cpu900_data_pkg::*;
    import cpu900_ctrl_pkg::*;

    phase_t phase;
    phase_t nx_phase;
    ctrl_t  nx_ctrl;
    logic   nx_wait;
    byte_t  op0;
    byte_t  op1;
    logic   prefix_ok;

    assign op0       = op_win[7:0];
    assign op1       = op_win[15:8];
    assign prefix_ok = (op0[7:6] == 2'b11) && (op0[5:4] != 2'd3); // 11zz with a real size

    // short register code to bank byte address
    function automatic reg_addr_t expand_reg(input logic [2:0] code);
        return {(code[2] ? 4'hF : 4'hE), code[1:0], 2'b00};
    endfunction

    always_comb begin
        fetched    = 2'd0;
        nx_phase   = phase;
        nx_ctrl    = ctrl;
        nx_wait    = alu_wait;
        nx_ctrl.op = ALU_NOP;  // move lasts a single cycle
        if (op_ok) begin
            case (phase)
                FETCH: begin
                    if (prefix_ok && op0[3]) begin
                        nx_ctrl.dst  = expand_reg(op0[2:0]);  // 11zz_1rrr
                        nx_ctrl.size = op0[5:4];
                        fetched      = 2'd1;
                        nx_phase     = EXEC;
                    end else if (prefix_ok && op0[3:0] == 4'b0111) begin
                        nx_ctrl.dst  = op1;  // explicit register byte
                        nx_ctrl.size = op0[5:4];
                        fetched      = 2'd2;
                        nx_phase     = EXEC;
                    end else begin
                        fetched = 2'd1;  // other forms skipped one byte at a time
                    end
                end
                EXEC: begin
                    nx_phase     = FETCH;
                    fetched      = 2'd1;
                    nx_ctrl.smux = 1'b0;
                    casez (op0)
                        8'b1000_1???: begin  // LD R,r
                            nx_ctrl.src = ctrl.dst;
                            nx_ctrl.dst = expand_reg(op0[2:0]);
                            nx_ctrl.op  = ALU_MOVE;
                        end
                        8'b1001_1???: begin  // LD r,R
                            nx_ctrl.src = expand_reg(op0[2:0]);
                            nx_ctrl.op  = ALU_MOVE;
                        end
                        8'b1010_1???: begin  // LD r,#3
                            nx_ctrl.imm  = {29'd0, op0[2:0]};
                            nx_ctrl.smux = 1'b1;
                            nx_ctrl.op   = ALU_MOVE;
                        end
                        8'b0000_0011: begin  // LD r,#
                            nx_ctrl.imm  = {24'd0, op1};
                            nx_ctrl.smux = 1'b1;
                            fetched      = 2'd2;
                            if (ctrl.size == SZ_BYTE) begin
                                nx_ctrl.op = ALU_MOVE;
                            end else begin
                                nx_wait  = 1'b1;  // upper bytes still to come
                                nx_phase = FILL_IMM;
                            end
                        end
                        default: ;  // unknown second byte dropped
                    endcase
                end
                FILL_IMM: begin
                    nx_wait    = 1'b0;
                    nx_phase   = FETCH;
                    nx_ctrl.op = ALU_MOVE;
                    if (ctrl.size == SZ_WORD) begin
                        nx_ctrl.imm[31:8] = {16'd0, op0};
                        fetched           = 2'd1;
                    end else begin
                        nx_ctrl.imm[31:8] = op_win[23:0];
                        fetched           = 2'd3;
                    end
                end
                default: nx_phase = FETCH;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= FETCH;
            ctrl     <= '0;  // op comes out as ALU_NOP
            alu_wait <= 1'b0;
        end else if (cen) begin
            phase    <= nx_phase;
            ctrl     <= nx_ctrl;
            alu_wait <= nx_wait;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu900_regs.sv ====
/* cpu900 register unit
   current bank E0-FF with a sized move and a writeback strobe per write */

`default_nettype none

`include "cpu900_defs.svh"

module cpu900_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  cpu900_ctrl_pkg::ctrl_t ctrl,
    output cpu900_data_pkg::wb_t   wb
);
    import cpu900_data_pkg::*;
    import cpu900_ctrl_pkg::*;

    localparam reg_addr_t BANK  = `CPU900_BANK_BASE;
    localparam int        NREGS = 256 - int'(BANK);
    localparam int        IW    = $clog2(NREGS);

    typedef logic [IW-1:0] idx_t;

    byte_t      rf [NREGS];
    idx_t       src_idx;
    idx_t       dst_idx;
    logic       dst_ok;
    logic [3:0] be;       // bytes written
    data_t      src_val;
    data_t      mask;
    data_t      result;
    logic       do_write;
    logic       wb_valid;
    reg_addr_t  wb_addr;
    data_t      wb_data;
    op_size_t   wb_size;

    always_comb begin
        src_idx = idx_t'(ctrl.src - BANK);
        dst_idx = idx_t'(ctrl.dst - BANK);
        case (ctrl.size)
            SZ_BYTE: begin be = 4'b0001; dst_ok = 1'b1;                  end
            SZ_WORD: begin be = 4'b0011; dst_ok = ~ctrl.dst[0];          end
            SZ_LONG: begin be = 4'b1111; dst_ok = ctrl.dst[1:0] == 2'b00; end
            default: begin be = 4'b0000; dst_ok = 1'b0;                  end
        endcase
        dst_ok = dst_ok && (ctrl.dst >= BANK);
        for (int i = 0; i < 4; i++) begin
            src_val[8*i +: 8] = (ctrl.src >= BANK) ? rf[src_idx + idx_t'(i)] : 8'h00; // off bank reads 0
            mask[8*i +: 8]    = {8{be[i]}};
        end
        result = (ctrl.smux ? ctrl.imm : src_val) & mask;
    end

    assign do_write = cen && (ctrl.op == ALU_MOVE) && dst_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                rf[i] <= '0;
            end
        end else if (do_write) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    rf[dst_idx + idx_t'(i)] <= result[8*i +: 8];  // aligned writes stay in the bank
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= do_write;  // one clk pulse per write
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            wb_addr <= ctrl.dst;
            wb_data <= result;
            wb_size <= ctrl.size;
        end
    end

    assign wb = '{valid: wb_valid, addr: wb_addr, data: wb_data, size: wb_size};

endmodule

`default_nettype wire

// ==== hdl/cpu900_core.sv ====
/* cpu900 front end top level
   operand queue feeding the opcode decoder feeding the register unit */

`default_nettype none

module cpu900_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    output logic                       mem_req,
    output cpu900_data_pkg::mem_addr_t mem_addr,
    input  logic                       mem_ack,
    input  cpu900_data_pkg::data_t     mem_data,
    output cpu900_data_pkg::wb_t       wb
);
    import cpu900_data_pkg::*;
    import cpu900_ctrl_pkg::*;

    data_t      op_win;
    logic       op_ok;
    logic [1:0] fetched;   // bytes retired this cycle
    ctrl_t      ctrl;

    cpu900_opq i_opq (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data),
        .fetched  (fetched),
        .op_win   (op_win),
        .op_ok    (op_ok)
    );

    cpu900_ctrl i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op_win   (op_win),
        .op_ok    (op_ok),
        .fetched  (fetched),
        .ctrl     (ctrl),
        .alu_wait ()           // only watched by the assertions
    );

    cpu900_regs i_regs (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .ctrl (ctrl),
        .wb   (wb)
    );

endmodule

`default_nettype wire

// ==== testbench/cpu900_props.sv ====
/* cpu900 protocol checks
   bound into the operand queue and the opcode decoder */

`default_nettype none

`include "cpu900_defs.svh"

module cpu900_props (
    input logic                               clk,
    input logic                               rst,
    input logic                               cen,
    input logic                               mem_req,
    input logic                               mem_ack,
    input logic [$clog2(`CPU900_OPQ_DEPTH):0] count,
    input logic [1:0]                         fetched,
    input logic                               op_ok,
    input logic                               alu_wait,
    input cpu900_ctrl_pkg::alu_op_t           op
);
    import cpu900_ctrl_pkg::*;

    logic in_flight;  // word requested and not yet acknowledged

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (cen) begin
            if (mem_req) begin
                in_flight <= 1'b1;
            end else if (mem_ack) begin
                in_flight <= 1'b0;
            end
        end
    end

    one_outstanding: assert property (@(posedge clk) disable iff (rst) in_flight |-> !mem_req)
        else $error("memory request issued while another is outstanding");

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        int'(count) <= `CPU900_OPQ_DEPTH)
        else $error("operand queue holds more bytes than its depth");

    no_fetch_starved: assert property (@(posedge clk) disable iff (rst) !op_ok |-> fetched == 2'd0)
        else $error("decoder retired bytes without a full opcode window");

    no_move_in_fill: assert property (@(posedge clk) disable iff (rst) alu_wait |-> op != ALU_MOVE)
        else $error("move issued while the immediate is still being filled");

endmodule

// queue side with the decoder inputs tied quiet
bind cpu900_opq cpu900_props i_opq_props (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .count    (count),
    .fetched  (fetched),
    .op_ok    (op_ok),
    .alu_wait (1'b0),
    .op       (cpu900_ctrl_pkg::ALU_NOP)
);

// decoder side with the memory inputs tied quiet
bind cpu900_ctrl cpu900_props i_ctrl_props (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .mem_req  (1'b0),
    .mem_ack  (1'b0),
    .count    ('0),
    .fetched  (fetched),
    .op_ok    (op_ok),
    .alu_wait (alu_wait),
    .op       (ctrl.op)
);

`default_nettype wire

// ==== testbench/cpu900_tb.sv ====
/* cpu900 front end testbench
   random load program, variable latency memory and a reference register model */

`default_nettype none

`include "cpu900_defs.svh"

module cpu900_tb;
    import cpu900_data_pkg::*;

    localparam int N_INS     = 300;
    localparam int N_TESTS   = 4;
    localparam int MEM_WORDS = 1 << `CPU900_MEM_AW;
    localparam int BANK      = int'(`CPU900_BANK_BASE);
    localparam int LIMIT     = N_INS * 40;   // cycles

    typedef struct packed {
        logic [1:0] kind;   // test index
        reg_addr_t  dst;
        reg_addr_t  src;
        logic       smux;   // immediate source
        data_t      imm;
        op_size_t   size;
    } ins_t;

    logic      clk      = 1'b0;
    logic      rst      = 1'b1;
    logic      cen      = 1'b0;
    logic      mem_ack  = 1'b0;
    data_t     mem_data = '0;
    logic      mem_req;
    mem_addr_t mem_addr;
    wb_t       wb;

    data_t     mem [MEM_WORDS];
    byte_t     prog [$];
    ins_t      ins_list [$];
    wb_t       exp_wb [$];
    int        exp_kind [$];
    int        seed = 32'h8401_a54c;
    int        checks [N_TESTS];
    int        errors [N_TESTS];
    int        exp_total;
    int        wb_seen;
    int        extra_err;
    int        n_req;
    int        addr_err;
    int        cycles;
    logic      cen_nx;
    logic      ack_busy;
    int        ack_delay;
    mem_addr_t ack_addr;
    mem_addr_t next_addr;

    cpu900_core i_cpu900_core (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data),
        .wb       (wb)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // three bit register codes sit four bytes apart from the bank base
    function automatic reg_addr_t short_reg(input logic [2:0] code);
        return reg_addr_t'(BANK + 4 * int'(code));
    endfunction

    // bytes past the program that never decode as a prefix
    function automatic data_t filler_word(input mem_addr_t a);
        return {1'b0, a[11:5], 3'b010, a[4:0], 8'h2a, 8'h15};
    endfunction

    function automatic string test_name(input int k);
        case (k)
            0:       return "reg_move";
            1:       return "imm3_load";
            2:       return "imm_load";
            default: return "explicit_reg";
        endcase
    endfunction

    task automatic gen_program();
        ins_t       ins;
        logic [2:0] r_code;
        logic [2:0] big_code;
        logic       expl;
        int         sub;
        for (int n = 0; n < N_INS; n++) begin
            ins      = '0;
            ins.size = op_size_t'($unsigned($random(seed)) % 3);
            ins.imm  = $random(seed);
            r_code   = 3'($random(seed));
            big_code = 3'($random(seed));
            expl     = ($unsigned($random(seed)) % 4) == 0;
            sub      = $unsigned($random(seed)) % 4;  // LD R,r / LD r,R / #3 / #
            if (expl) begin
                ins.kind = 2'd3;
                ins.dst  = ($unsigned($random(seed)) % 4 == 0) ? {1'b0, 7'($random(seed))}
                                                               : {3'b111, 5'($random(seed))};
                prog.push_back({2'b11, ins.size, 4'b0111});
                prog.push_back(ins.dst);
                if (sub == 0) begin
                    sub = 1;  // explicit register only as destination
                end
            end else begin
                ins.kind = (sub < 2) ? 2'd0 : 2'(sub - 1);
                ins.dst  = short_reg(r_code);
                prog.push_back({2'b11, ins.size, 1'b1, r_code});
            end
            case (sub)
                0: begin
                    prog.push_back({5'b10001, big_code});
                    ins.src = ins.dst;
                    ins.dst = short_reg(big_code);
                end
                1: begin
                    prog.push_back({5'b10011, big_code});
                    ins.src = short_reg(big_code);
                end
                2: begin
                    prog.push_back({5'b10101, ins.imm[2:0]});
                    ins.imm  = {29'd0, ins.imm[2:0]};
                    ins.smux = 1'b1;
                end
                default: begin
                    prog.push_back(8'h03);
                    for (int b = 0; b < (1 << ins.size); b++) begin
                        prog.push_back(ins.imm[8*b +: 8]);  // low byte first
                    end
                    ins.smux = 1'b1;
                end
            endcase
            ins_list.push_back(ins);
        end
        while (prog.size() % 4 != 0) begin
            prog.push_back(8'h00);
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            if (w < prog.size() / 4) begin
                mem[w] = {prog[4*w+3], prog[4*w+2], prog[4*w+1], prog[4*w]};
            end else begin
                mem[w] = filler_word(mem_addr_t'(w));
            end
        end
    endtask

    // replays the instructions on a little endian 32 byte bank
    task automatic run_model();
        byte_t rf_m [32];
        data_t val;
        int    nb;
        int    dst;
        wb_t   e;
        foreach (rf_m[i]) begin
            rf_m[i] = 8'h00;
        end
        foreach (ins_list[n]) begin
            nb  = 1 << ins_list[n].size;
            dst = int'(ins_list[n].dst);
            val = '0;
            for (int b = 0; b < nb; b++) begin
                val[8*b +: 8] = ins_list[n].smux ? ins_list[n].imm[8*b +: 8]
                                                 : rf_m[int'(ins_list[n].src) - BANK + b];
            end
            if (dst >= BANK && dst % nb == 0) begin
                for (int b = 0; b < nb; b++) begin
                    rf_m[dst - BANK + b] = val[8*b +: 8];
                end
                e = '{valid: 1'b1, addr: ins_list[n].dst, data: val, size: ins_list[n].size};
                exp_wb.push_back(e);
                exp_kind.push_back(int'(ins_list[n].kind));
            end
        end
    endtask

    // cen gaps and program memory with acks only in cen cycles
    always @(posedge clk) begin
        if (rst) begin
            cen       <= 1'b0;
            mem_ack   <= 1'b0;
            ack_busy  = 1'b0;
            next_addr = '0;
        end else begin
            cen_nx = ($unsigned($random(seed)) % 8) != 0;
            cen     <= cen_nx;
            mem_ack <= 1'b0;
            if (mem_req) begin
                n_req++;
                assert (mem_addr == next_addr) else begin
                    $display("ERR mem_addr expected %03h actual %03h", next_addr, mem_addr);
                    addr_err++;
                end
                next_addr = next_addr + 1'b1;
                ack_addr  = mem_addr;
                ack_delay = 1 + $unsigned($random(seed)) % 4;
                ack_busy  = 1'b1;
            end else if (ack_busy) begin
                if (ack_delay > 1) begin
                    ack_delay--;
                end else if (cen_nx) begin
                    mem_ack  <= 1'b1;
                    mem_data <= mem[ack_addr];
                    ack_busy = 1'b0;
                end
            end
        end
    end

    // in order scoreboard
    always @(posedge clk) begin
        wb_t e;
        int  k;
        if (!rst && wb.valid) begin
            wb_seen++;
            assert (exp_wb.size() != 0) else begin
                $display("writeback to %02h arrived with no expected write left", wb.addr);
                extra_err++;
            end
            if (exp_wb.size() != 0) begin
                e = exp_wb.pop_front();
                k = exp_kind.pop_front();
                checks[k]++;
                assert (wb == e) else begin
                    $display("ERR %s expected %02h:%08h size %0d actual %02h:%08h size %0d",
                             test_name(k), e.addr, e.data, e.size, wb.addr, wb.data, wb.size);
                    errors[k]++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d writebacks seen",
                     LIMIT, wb_seen, exp_total);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int fails;
        int nchk;
        gen_program();
        run_model();
        exp_total = exp_wb.size();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (wb_seen < exp_total) begin
            @(negedge clk);
        end
        repeat (100) @(negedge clk);  // room for stray writebacks
        fails = extra_err + addr_err;
        nchk  = 1 + n_req;
        for (int k = 0; k < N_TESTS; k++) begin
            $display("test %s: %0d checks, %0d errors", test_name(k), checks[k], errors[k]);
            fails += errors[k];
            nchk  += checks[k];
        end
        $display("test mem_addr: %0d requests, %0d errors", n_req, addr_err);
        assert (wb_seen == exp_total) else begin
            $display("ERR wb_count expected %0d actual %0d", exp_total, wb_seen);
            fails++;
        end
        $display("test wb_count: %0d writebacks, model %0d", wb_seen, exp_total);
        $display("total: %0d checks, %0d errors", nchk, fails);
        if (fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/cpu900_data_pkg.sv
hdl/cpu900_ctrl_pkg.sv
hdl/cpu900_opq.sv
hdl/cpu900_ctrl.sv
hdl/cpu900_regs.sv
hdl/cpu900_core.sv
testbench/cpu900_props.sv
testbench/cpu900_tb.sv

// ==== Makefile ====
# Verilator build and run of the cpu900 front end testbench

SIM := obj_dir/cpu900_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, fail unless the pass line is printed"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cpu900_tb -o cpu900_sim
	./$(SIM) | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null

clean:
	rm -rf obj_dir
